//--- verilog/vga_defines.svh
// XGA 1024x768 timing with fixed button geometry, all values sized to the 11-bit coordinate
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// Horizontal timing in pixel clocks
`define H_ACTIVE      11'd1024
`define H_SYNC_START  11'd1048
`define H_SYNC_END    11'd1184
`define H_TOTAL       11'd1344

// Vertical timing in lines
`define V_ACTIVE      11'd768
`define V_SYNC_START  11'd771
`define V_SYNC_END    11'd777
`define V_TOTAL       11'd806

// Last visible column and line, where the frame border sits
`define FRAME_H_LAST  11'd1023
`define FRAME_V_LAST  11'd767

// Buttons share one row and one size
`define BTN_Y         11'd668
`define BTN_W         11'd100
`define BTN_H         11'd50
`define BTN1_X        11'd342
`define BTN2_X        11'd462
`define BTN3_X        11'd582

// 4:4:4 colors
`define COLOR_BLACK   12'h000
`define COLOR_BG      12'h888
`define COLOR_BORDER  12'hFFF
`define COLOR_BTN1    12'hF00
`define COLOR_BTN2    12'h00F
`define COLOR_BTN3    12'h0F0

`endif

//--- verilog/vga_pkg.sv
// Shared types for the pixel pipeline; coordinates cover counts up to 2047 only
package vga_pkg;

  // Pixel or line count, wide enough for H_TOTAL
  typedef logic [10:0] coord_t;

  // Color as 4 bits each of red, green, blue
  typedef logic [11:0] rgb_t;

  // Screen shown by the menu
  typedef enum logic [2:0] {
    MENU  = 3'd0, // Start button only
    PLAY  = 3'd1, // Two game buttons
    PAUSE = 3'd2  // No buttons
  } screen_t;

endpackage

//--- verilog/vga_if.sv
// One pixel per clock with no handshake; the driver must present a new pixel every cycle
`timescale 1ns/1ps

interface vga_if import vga_pkg::*; ();

  coord_t hcount; // Column of this pixel
  coord_t vcount; // Line of this pixel
  logic   hsync;  // Horizontal sync, active high
  logic   vsync;  // Vertical sync, active high
  logic   hblnk;  // Outside the active columns
  logic   vblnk;  // Outside the active lines
  rgb_t   rgb;    // Pixel color

  modport out (
    output hcount, vcount,
    output hsync, vsync, hblnk, vblnk,
    output rgb
  );

  modport in (
    input hcount, vcount,
    input hsync, vsync, hblnk, vblnk,
    input rgb
  );

endinterface

//--- verilog/vga_timing.sv
// XGA counters with fixed timing from the defines header; rgb is always 0 at this stage
`timescale 1ns/1ps

`include "vga_defines.svh"

module vga_timing import vga_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.out   vga_out
);

  coord_t hcount_nxt; // Column for the next clock
  coord_t vcount_nxt; // Line for the next clock
  logic   h_wrap;     // Last column of a line
  logic   v_wrap;     // Last line of a frame

  always_comb begin
    h_wrap = (vga_out.hcount == (`H_TOTAL - 11'd1));
    v_wrap = (vga_out.vcount == (`V_TOTAL - 11'd1));

    if (h_wrap) begin
      hcount_nxt = '0;
    end else begin
      hcount_nxt = vga_out.hcount + 11'd1;
    end

    // Line advances only when a line ends
    if (!h_wrap) begin
      vcount_nxt = vga_out.vcount;
    end else if (v_wrap) begin
      vcount_nxt = '0;
    end else begin
      vcount_nxt = vga_out.vcount + 11'd1;
    end
  end

  // Flags are computed from the next count so they line up with it
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out.hcount <= '0;
      vga_out.vcount <= '0;
      vga_out.hsync  <= 1'b0;
      vga_out.vsync  <= 1'b0;
      vga_out.hblnk  <= 1'b0;
      vga_out.vblnk  <= 1'b0;
    end else begin
      vga_out.hcount <= hcount_nxt;
      vga_out.vcount <= vcount_nxt;
      vga_out.hsync  <= (hcount_nxt >= `H_SYNC_START) &&
                        (hcount_nxt < `H_SYNC_END);        // Sync window
      vga_out.vsync  <= (vcount_nxt >= `V_SYNC_START) &&
                        (vcount_nxt < `V_SYNC_END);
      vga_out.hblnk  <= (hcount_nxt >= `H_ACTIVE);           // Right porch onwards
      vga_out.vblnk  <= (vcount_nxt >= `V_ACTIVE);           // Bottom porch onwards
    end
  end

  assign vga_out.rgb = `COLOR_BLACK; // No color before the background stage

endmodule

//--- verilog/draw_bg.sv
// Background stage with one cycle of latency; the border assumes an XGA active area
`timescale 1ns/1ps

`include "vga_defines.svh"

module draw_bg import vga_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.in    vga_in,
  vga_if.out   vga_out
);

  rgb_t rgb_nxt; // Background color for the incoming pixel
  logic on_edge; // Pixel on the one-pixel frame

  always_comb begin
    on_edge = (vga_in.hcount == '0) || (vga_in.hcount == `FRAME_H_LAST) ||
              (vga_in.vcount == '0) || (vga_in.vcount == `FRAME_V_LAST);

    if (vga_in.hblnk || vga_in.vblnk) begin
      rgb_nxt = `COLOR_BLACK;  // Blanking must stay black
    end else if (on_edge) begin
      rgb_nxt = `COLOR_BORDER; // White frame
    end else begin
      rgb_nxt = `COLOR_BG;     // Gray fill
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out.hcount <= '0;
      vga_out.vcount <= '0;
      vga_out.hsync  <= 1'b0;
      vga_out.vsync  <= 1'b0;
      vga_out.hblnk  <= 1'b0;
      vga_out.vblnk  <= 1'b0;
      vga_out.rgb    <= '0;
    end else begin
      vga_out.hcount <= vga_in.hcount;
      vga_out.vcount <= vga_in.vcount;
      vga_out.hsync  <= vga_in.hsync;
      vga_out.vsync  <= vga_in.vsync;
      vga_out.hblnk  <= vga_in.hblnk;
      vga_out.vblnk  <= vga_in.vblnk;
      vga_out.rgb    <= rgb_nxt;
    end
  end

endmodule

//--- verilog/draw_buttons.sv
// Button overlay with one cycle of latency; buttons must lie inside the active area
`timescale 1ns/1ps

`include "vga_defines.svh"

module draw_buttons import vga_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  screen_t screen,
  vga_if.in       vga_in,
  vga_if.out      vga_out
);

  rgb_t rgb_nxt; // Color after the overlay
  logic in_row;  // Pixel on the button row
  logic in_btn1; // Inside button 1 rectangle
  logic in_btn2; // Inside button 2 rectangle
  logic in_btn3; // Inside button 3 rectangle

  always_comb begin
    in_row  = (vga_in.vcount >= `BTN_Y) && (vga_in.vcount < (`BTN_Y + `BTN_H));
    in_btn1 = in_row && (vga_in.hcount >= `BTN1_X) &&
              (vga_in.hcount < (`BTN1_X + `BTN_W));
    in_btn2 = in_row && (vga_in.hcount >= `BTN2_X) &&
              (vga_in.hcount < (`BTN2_X + `BTN_W));
    in_btn3 = in_row && (vga_in.hcount >= `BTN3_X) &&
              (vga_in.hcount < (`BTN3_X + `BTN_W));

    // Rectangles do not overlap, so order does not matter
    if (in_btn1 && (screen == MENU)) begin
      rgb_nxt = `COLOR_BTN1;          // Start button
    end else if (in_btn2 && (screen == PLAY)) begin
      rgb_nxt = `COLOR_BTN2;
    end else if (in_btn3 && (screen == PLAY)) begin
      rgb_nxt = `COLOR_BTN3;
    end else begin
      rgb_nxt = vga_in.rgb;           // Background shows through
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out.hcount <= '0;
      vga_out.vcount <= '0;
      vga_out.hsync  <= 1'b0;
      vga_out.vsync  <= 1'b0;
      vga_out.hblnk  <= 1'b0;
      vga_out.vblnk  <= 1'b0;
      vga_out.rgb    <= '0;
    end else begin
      vga_out.hcount <= vga_in.hcount;
      vga_out.vcount <= vga_in.vcount;
      vga_out.hsync  <= vga_in.hsync;
      vga_out.vsync  <= vga_in.vsync;
      vga_out.hblnk  <= vga_in.hblnk;
      vga_out.vblnk  <= vga_in.vblnk;
      vga_out.rgb    <= rgb_nxt;
    end
  end

endmodule

//--- verilog/menu_state.sv
// Screen FSM that changes only at frame start; at most one transition per frame
`timescale 1ns/1ps

module menu_state import vga_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    key_start,
  input  logic    key_pause,
  input  logic    key_back,
  vga_if.in       tim_in,
  output screen_t screen
);

  logic    start_pend;  // Start seen this frame
  logic    pause_pend;  // Pause seen this frame
  logic    back_pend;   // Back seen this frame
  logic    frame_start; // Timing shows pixel (0, 0)
  screen_t screen_nxt;

  assign frame_start = (tim_in.hcount == '0) && (tim_in.vcount == '0);

  // Back wins over start, start over pause
  always_comb begin
    screen_nxt = screen;
    if (back_pend && ((screen == PLAY) || (screen == PAUSE))) begin
      screen_nxt = MENU;
    end else if (start_pend && ((screen == MENU) || (screen == PAUSE))) begin
      screen_nxt = PLAY;
    end else if (pause_pend && (screen == PLAY)) begin
      screen_nxt = PAUSE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start_pend <= 1'b0;
      pause_pend <= 1'b0;
      back_pend  <= 1'b0;
      screen     <= MENU;
    end else if (frame_start) begin
      screen     <= screen_nxt;   // Applied before the first visible pixel
      start_pend <= key_start;    // Keys on this cycle carry to next frame
      pause_pend <= key_pause;
      back_pend  <= key_back;
    end else begin
      start_pend <= start_pend | key_start;
      pause_pend <= pause_pend | key_pause;
      back_pend  <= back_pend | key_back;
    end
  end

endmodule

//--- verilog/vga_menu_top.sv
// Menu screen top level; clk must be the 65 MHz XGA pixel clock, keys are one-cycle pulses
`timescale 1ns/1ps

module vga_menu_top import vga_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    key_start,
  input  logic    key_pause,
  input  logic    key_back,
  output logic    hsync,
  output logic    vsync,
  output rgb_t    rgb,
  output screen_t screen
);

  vga_if tim_if ();       // Counters and sync
  vga_if bg_if ();        // After background
  vga_if btn_if ();       // After buttons, two cycles behind tim_if

  vga_timing u_vga_timing (
    .clk     (clk),
    .rst     (rst),
    .vga_out (tim_if.out)
  );

  draw_bg u_draw_bg (
    .clk     (clk),
    .rst     (rst),
    .vga_in  (tim_if.in),
    .vga_out (bg_if.out)
  );

  draw_buttons u_draw_buttons (
    .clk     (clk),
    .rst     (rst),
    .screen  (screen),
    .vga_in  (bg_if.in),
    .vga_out (btn_if.out)
  );

  menu_state u_menu_state (
    .clk       (clk),
    .rst       (rst),
    .key_start (key_start),
    .key_pause (key_pause),
    .key_back  (key_back),
    .tim_in    (tim_if.in),
    .screen    (screen)
  );

  assign hsync = btn_if.hsync;
  assign vsync = btn_if.vsync;
  assign rgb   = btn_if.rgb;

endmodule

//--- verification/vga_menu_tb.sv
// Runs three full XGA frames with random key pulses; expects the two-stage latency of the top level
`timescale 1ns/1ps

`include "vga_defines.svh"

module vga_menu_tb import vga_pkg::*; ();

  localparam int CLK_HALF     = 50;                                  // 100 ns period
  localparam int RESET_CYCLES = 2;
  localparam int FRAME_CYCLES = int'(`H_TOTAL) * int'(`V_TOTAL);     // 1,083,264
  localparam int RUN_CYCLES   = 3 * FRAME_CYCLES;                    // Three frames
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 4 * FRAME_CYCLES) * 2 * CLK_HALF;
  localparam int KEY_BITS     = 18;                                  // About 1 press in 2^18
  localparam int MAX_SHOWN    = 10;                                  // Printed mismatches per test
  localparam int NUM_TESTS    = 5;

  logic    clk;
  logic    rst;
  logic    key_start;
  logic    key_pause;
  logic    key_back;
  logic    hsync;
  logic    vsync;
  rgb_t    rgb;
  screen_t screen;

  logic [31:0] lfsr_state;   // Key stimulus source
  coord_t      mh, mv;       // Model of the timing counters
  coord_t      bg_h, bg_v;   // Pixel held in the background stage
  logic        bg_hs, bg_vs;
  rgb_t        bg_rgb;
  logic        exp_hs, exp_vs;
  rgb_t        exp_rgb;      // Expected at the ports on the next sample
  logic        exp_in_btn;   // Expected pixel lies in a button rectangle
  screen_t     scr_m;        // Screen model
  logic        ps, pp, pb;   // Pending start, pause, back
  int          screen_changes;
  int          checks [NUM_TESTS];
  int          errors [NUM_TESTS];
  string       test_name [NUM_TESTS] = '{"reset", "sync timing", "background", "buttons",
                                         "state changes"};

  vga_menu_top DUT (
    .clk       (clk),
    .rst       (rst),
    .key_start (key_start),
    .key_pause (key_pause),
    .key_back  (key_back),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb),
    .screen    (screen)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // Fires only when all taken bits are zero
  function automatic logic key_fires();
    logic any_one;
    any_one = 1'b0;
    for (int i = 0; i < KEY_BITS; i++) begin
      any_one    = any_one | lfsr_state[0]; // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return !any_one;
  endfunction

  function automatic logic in_rect(input coord_t h, input coord_t v, input coord_t x);
    return (v >= `BTN_Y) && (v < `BTN_Y + `BTN_H) && (h >= x) && (h < x + `BTN_W);
  endfunction

  function automatic rgb_t bg_color(input coord_t h, input coord_t v);
    if ((h >= `H_ACTIVE) || (v >= `V_ACTIVE)) return 12'h000;   // Blanking
    if ((h == 11'd0) || (h == `H_ACTIVE - 11'd1) ||
        (v == 11'd0) || (v == `V_ACTIVE - 11'd1)) return `COLOR_BORDER;
    return `COLOR_BG;
  endfunction

  function automatic rgb_t overlay(input coord_t h, input coord_t v, input rgb_t c,
                                   input screen_t s);
    if (in_rect(h, v, `BTN1_X) && (s == MENU)) return `COLOR_BTN1;
    if (in_rect(h, v, `BTN2_X) && (s == PLAY)) return `COLOR_BTN2;
    if (in_rect(h, v, `BTN3_X) && (s == PLAY)) return `COLOR_BTN3;
    return c;
  endfunction

  // One step per frame, back before start before pause
  function automatic screen_t next_screen(input screen_t s, input logic b, input logic st,
                                          input logic p);
    if (b && ((s == PLAY) || (s == PAUSE))) return MENU;
    if (st && ((s == MENU) || (s == PAUSE))) return PLAY;
    if (p && (s == PLAY)) return PAUSE;
    return s;
  endfunction

  task automatic check_value(input string name, input int test_id,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks[test_id]++;
    if (expected !== actual) begin
      errors[test_id]++;
      if (errors[test_id] <= MAX_SHOWN) begin
        $display("Fail %s expected %h actual %h at %0t ns", name, expected, actual, $time);
      end
    end
  endtask

  initial begin
    int      tid;
    int      total_checks;
    int      total_errors;
    logic    ks, kp, kb;
    screen_t scr_nf;
    rst        = 1'b1;
    key_start  = 1'b0;
    key_pause  = 1'b0;
    key_back   = 1'b0;
    lfsr_state = 32'd73137;
    mh         = '0;
    mv         = '0;
    bg_h       = '0;   // Stage registers hold zeros after reset
    bg_v       = '0;
    bg_hs      = 1'b0;
    bg_vs      = 1'b0;
    bg_rgb     = '0;
    exp_hs     = 1'b0;
    exp_vs     = 1'b0;
    exp_rgb    = '0;
    exp_in_btn = 1'b0;
    scr_m      = MENU;
    ps         = 1'b0;
    pp         = 1'b0;
    pb         = 1'b0;
    screen_changes = 0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("hsync", 0, 32'd0, 32'(hsync));
      check_value("vsync", 0, 32'd0, 32'(vsync));
      check_value("rgb", 0, 32'd0, 32'(rgb));
      check_value("screen", 0, 32'(MENU), 32'(screen));
    end
    rst = 1'b0;

    // Sample k sees timing pixel k and port pixel k - 2
    for (int k = 0; k < RUN_CYCLES; k++) begin
      tid = (k < 2) ? 0 : 1;
      check_value("hsync", tid, 32'(exp_hs), 32'(hsync));
      check_value("vsync", tid, 32'(exp_vs), 32'(vsync));
      if (k < 2) tid = 0;
      else if (exp_in_btn) tid = 3;
      else tid = 2;
      check_value("rgb", tid, 32'(exp_rgb), 32'(rgb));
      check_value("screen", (k < 2) ? 0 : 4, 32'(scr_m), 32'(screen));

      ks = key_fires();
      kp = key_fires();
      kb = key_fires();
      if ((k >= FRAME_CYCLES) && (k < 2 * FRAME_CYCLES)) begin
        ks = 1'b0;                           // Frame 1 carries only the directed press
        kp = 1'b0;
        kb = 1'b0;
      end
      if (k == FRAME_CYCLES) begin           // Press on a frame-start cycle
        scr_nf = next_screen(scr_m, pb, ps, pp);
        if (scr_nf == PLAY) begin
          kp = 1'b1;                         // Frame 2 shows PAUSE
        end else begin
          ks = 1'b1;                         // Frame 2 shows PLAY
        end
      end
      key_start = ks;
      key_pause = kp;
      key_back  = kb;

      // Button stage takes the background pixel with the current screen
      exp_hs     = bg_hs;
      exp_vs     = bg_vs;
      exp_rgb    = overlay(bg_h, bg_v, bg_rgb, scr_m);
      exp_in_btn = in_rect(bg_h, bg_v, `BTN1_X) || in_rect(bg_h, bg_v, `BTN2_X) ||
                   in_rect(bg_h, bg_v, `BTN3_X);
      bg_h   = mh;
      bg_v   = mv;
      bg_hs  = (mh >= `H_SYNC_START) && (mh < `H_SYNC_END);
      bg_vs  = (mv >= `V_SYNC_START) && (mv < `V_SYNC_END);
      bg_rgb = bg_color(mh, mv);

      if ((mh == 11'd0) && (mv == 11'd0)) begin
        if (next_screen(scr_m, pb, ps, pp) != scr_m) screen_changes++;
        scr_m = next_screen(scr_m, pb, ps, pp);
        ps = ks;                             // Kept for the next frame
        pp = kp;
        pb = kb;
      end else begin
        ps = ps | ks;
        pp = pp | kp;
        pb = pb | kb;
      end

      if (mh == `H_TOTAL - 11'd1) begin
        mh = '0;
        mv = (mv == `V_TOTAL - 11'd1) ? 11'd0 : mv + 11'd1;
      end else begin
        mh = mh + 11'd1;
      end
      @(negedge clk);
    end

    total_checks = 0;
    total_errors = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      $display("Test %0d %s: %0d checks, %0d errors, %s", i + 1, test_name[i], checks[i],
               errors[i], (errors[i] == 0) ? "passed" : "failed");
      total_checks += checks[i];
      total_errors += errors[i];
    end
    $display("Screen changes seen: %0d; totals: %0d checks, %0d errors", screen_changes,
             total_checks, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Four frames is well past the three-frame run
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not end within four frames of simulated time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- vga_menu_top.f
+incdir+verilog
verilog/vga_pkg.sv
verilog/vga_if.sv
verilog/vga_timing.sv
verilog/draw_bg.sv
verilog/draw_buttons.sv
verilog/menu_state.sv
verilog/vga_menu_top.sv
verification/vga_menu_tb.sv

//--- Makefile
# Verilator build and run for the VGA menu testbench

VERILATOR ?= verilator
TOP       ?= vga_menu_tb
FILELIST  ?= vga_menu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
